//--- mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// data path width, one word
`define MEM_DW 32

// word address width of the data RAM
`define MEM_AW 10

// MIPS primary opcodes for loads
`define OP_LB  6'h20
`define OP_LH  6'h21
`define OP_LW  6'h23
`define OP_LBU 6'h24
`define OP_LHU 6'h25

// MIPS primary opcodes for stores
`define OP_SB  6'h28
`define OP_SH  6'h29
`define OP_SW  6'h2b

`endif

//--- mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

    // memory opcodes, values follow the MIPS primary opcode field
    typedef enum logic [5:0] {
        OP_NONE = 6'h00,
        OP_LB   = `OP_LB,
        OP_LH   = `OP_LH,
        OP_LW   = `OP_LW,
        OP_LBU  = `OP_LBU,
        OP_LHU  = `OP_LHU,
        OP_SB   = `OP_SB,
        OP_SH   = `OP_SH,
        OP_SW   = `OP_SW
    } mem_op_e;

    // access size derived from the opcode
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

endpackage

//--- struct_conflict.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module struct_conflict import mem_pkg::*; (
    // control
    input  logic               E_exp1,
    input  logic               E_exp2,
    input  logic               M_flush,
    input  logic               M_ena,
    // slot A
    input  logic               E_mem_en1,
    input  logic               E_mem_ren1,
    input  logic               E_mem_wen1,
    input  mem_op_e            E_mem_op1,
    input  logic [`MEM_DW-1:0] E_mem_addr1,
    input  logic [`MEM_DW-1:0] E_mem_wdata1,
    output logic               E_mem_adel1,
    output logic               E_mem_ades1,
    output logic               E_mem_sel1,
    // slot B
    input  logic               E_mem_en2,
    input  logic               E_mem_ren2,
    input  logic               E_mem_wen2,
    input  mem_op_e            E_mem_op2,
    input  logic [`MEM_DW-1:0] E_mem_addr2,
    input  logic [`MEM_DW-1:0] E_mem_wdata2,
    output logic               E_mem_adel2,
    output logic               E_mem_ades2,
    output logic               E_mem_sel2,
    // merged port
    output logic               E_mem_en,
    output logic               E_mem_ren,
    output logic               E_mem_wen,
    output mem_op_e            E_mem_op,
    output logic [`MEM_DW-1:0] E_mem_addr,
    output logic [`MEM_DW-1:0] E_mem_wdata
);

    logic kill_a;
    logic kill_b;

    // word loads need both low bits clear, halfword loads only bit 0
    function automatic logic load_misaligned(mem_op_e op, logic [1:0] lo);
        case (op)
            OP_LW:         return |lo;
            OP_LH, OP_LHU: return lo[0];
            default:       return 1'b0;
        endcase
    endfunction

    function automatic logic store_misaligned(mem_op_e op, logic [1:0] lo);
        case (op)
            OP_SW:   return |lo;
            OP_SH:   return lo[0];
            default: return 1'b0;
        endcase
    endfunction

    // a disabled slot may carry a stale opcode, so no error from it
    assign E_mem_adel1 = E_mem_en1 & load_misaligned(E_mem_op1, E_mem_addr1[1:0]);
    assign E_mem_ades1 = E_mem_en1 & store_misaligned(E_mem_op1, E_mem_addr1[1:0]);
    assign E_mem_adel2 = E_mem_en2 & load_misaligned(E_mem_op2, E_mem_addr2[1:0]);
    assign E_mem_ades2 = E_mem_en2 & store_misaligned(E_mem_op2, E_mem_addr2[1:0]);

    // anything wrong in slot A also kills the younger slot B
    assign kill_a = E_exp1 | E_mem_adel1 | E_mem_ades1;
    assign kill_b = kill_a | E_exp2 | E_mem_adel2 | E_mem_ades2;

    assign E_mem_sel1 = E_mem_en1 & ~kill_a;
    assign E_mem_sel2 = E_mem_en2 & ~kill_b;

    // port only fires when M can take the access
    assign E_mem_en  = (E_mem_sel1 | E_mem_sel2) & M_ena & ~M_flush;
    assign E_mem_ren = (E_mem_sel1 & E_mem_ren1) | (E_mem_sel2 & E_mem_ren2);
    assign E_mem_wen = (E_mem_sel1 & E_mem_wen1) | (E_mem_sel2 & E_mem_wen2);

    assign E_mem_op = E_mem_sel1 ? E_mem_op1 :
                      E_mem_sel2 ? E_mem_op2 : OP_NONE;

    assign E_mem_addr  = ({`MEM_DW{E_mem_sel1}} & E_mem_addr1)
                       | ({`MEM_DW{E_mem_sel2}} & E_mem_addr2);
    assign E_mem_wdata = ({`MEM_DW{E_mem_sel1}} & E_mem_wdata1)
                       | ({`MEM_DW{E_mem_sel2}} & E_mem_wdata2);

    // issue never pairs two memory ops, the merge relies on it
    always_comb begin
        assert (!(E_mem_en1 && E_mem_en2))
            else $error("both slots issued a memory access in one cycle");
    end

endmodule

//--- mem_align.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_align import mem_pkg::*; (
    // E side, merged request
    input  logic               E_mem_en,
    input  logic               E_mem_wen,
    input  mem_op_e            E_mem_op,
    input  logic [`MEM_DW-1:0] E_mem_addr,
    input  logic [`MEM_DW-1:0] E_mem_wdata,
    output logic [3:0]         ram_we,
    output logic [`MEM_AW-1:0] ram_addr,
    output logic [`MEM_DW-1:0] ram_wdata,
    // M side, returned word
    input  logic               M_mem_sel1,
    input  logic               M_mem_sel2,
    input  mem_op_e            M_mem_op,
    input  logic [1:0]         M_addr_lo,
    input  logic [`MEM_DW-1:0] ram_rdata,
    output logic [`MEM_DW-1:0] M_mem_rdata1,
    output logic [`MEM_DW-1:0] M_mem_rdata2
);

    mem_size_e          e_size;
    mem_size_e          m_size;
    logic [7:0]         m_byte;
    logic [15:0]        m_half;
    logic [`MEM_DW-1:0] load_data;

    function automatic mem_size_e op_size(mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SZ_BYTE;
            OP_LH, OP_LHU, OP_SH: return SZ_HALF;
            default:              return SZ_WORD;
        endcase
    endfunction

    assign e_size = op_size(E_mem_op);
    assign m_size = op_size(M_mem_op);

    // store lanes, little endian
    assign ram_addr = E_mem_addr[`MEM_AW+1:2];

    always_comb begin
        ram_we    = 4'b0000;
        ram_wdata = E_mem_wdata;
        case (e_size)
            SZ_BYTE: begin
                ram_wdata = {4{E_mem_wdata[7:0]}};
                ram_we    = 4'b0001 << E_mem_addr[1:0];
            end
            SZ_HALF: begin
                ram_wdata = {2{E_mem_wdata[15:0]}};
                ram_we    = E_mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                ram_we = 4'b1111;
            end
        endcase
        // only a live store touches the RAM
        if (!(E_mem_en && E_mem_wen)) begin
            ram_we = 4'b0000;
        end
    end

    // load lane pick from the registered low address bits
    assign m_byte = ram_rdata[8*M_addr_lo +: 8];
    assign m_half = M_addr_lo[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        load_data = '0;
        case (M_mem_op)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                case (m_size)
                    SZ_BYTE: begin
                        if (M_mem_op == OP_LB) begin
                            load_data = {{(`MEM_DW-8){m_byte[7]}}, m_byte};
                        end else begin
                            load_data = {{(`MEM_DW-8){1'b0}}, m_byte};
                        end
                    end
                    SZ_HALF: begin
                        if (M_mem_op == OP_LH) begin
                            load_data = {{(`MEM_DW-16){m_half[15]}}, m_half};
                        end else begin
                            load_data = {{(`MEM_DW-16){1'b0}}, m_half};
                        end
                    end
                    default: begin
                        load_data = ram_rdata;
                    end
                endcase
            end
            // stores and bubbles return nothing
            default: begin
                load_data = '0;
            end
        endcase
    end

    // steer to the owning slot, the other one sees zero
    assign M_mem_rdata1 = {`MEM_DW{M_mem_sel1}} & load_data;
    assign M_mem_rdata2 = {`MEM_DW{M_mem_sel2}} & load_data;

endmodule

//--- em_pipe_reg.sv
`timescale 1ns/1ps

module em_pipe_reg import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       M_ena,
    input  logic       M_flush,
    input  logic       E_mem_sel1,
    input  logic       E_mem_sel2,
    input  mem_op_e    E_mem_op,
    input  logic [1:0] E_addr_lo,
    output logic       M_mem_sel1,
    output logic       M_mem_sel2,
    output mem_op_e    M_mem_op,
    output logic [1:0] M_addr_lo
);

    // slot selects and opcode
    always_ff @(posedge clk) begin
        if (rst) begin
            M_mem_sel1 <= 1'b0;
            M_mem_sel2 <= 1'b0;
            M_mem_op   <= OP_NONE;
        end else if (M_ena) begin
            if (M_flush) begin
                M_mem_sel1 <= 1'b0;
                M_mem_sel2 <= 1'b0;
                M_mem_op   <= OP_NONE;
            end else begin
                M_mem_sel1 <= E_mem_sel1;
                M_mem_sel2 <= E_mem_sel2;
                M_mem_op   <= E_mem_op;
            end
        end
    end

    // lane offset for the load extract
    always_ff @(posedge clk) begin
        if (M_ena) begin
            M_addr_lo <= E_addr_lo;
        end
    end

    // one owner per returned word, needs the issue and kill logic upstream
    a_one_sel: assert property (
        @(posedge clk) disable iff (rst) !(M_mem_sel1 && M_mem_sel2)
    ) else $error("both M selects set");

endmodule

//--- data_ram.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module data_ram #(
    parameter int DEPTH_LOG2 = `MEM_AW
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic [3:0]            we,
    input  logic [DEPTH_LOG2-1:0] addr,
    input  logic [`MEM_DW-1:0]    wdata,
    output logic [`MEM_DW-1:0]    rdata
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [`MEM_DW-1:0] mem [0:DEPTH-1];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // byte writes
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[addr];
        end
    end

    // lane enables must come with an accepted access, a stalled or flushed
    // store has to arrive here with we cleared
    a_we_gated: assert property (
        @(posedge clk) disable iff (rst) !en |-> (we == 4'b0000)
    ) else $error("byte enables set without an access");

endmodule

//--- mem_stage_top.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_stage_top import mem_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // slot A
    input  logic               E_mem_en1,
    input  logic               E_mem_ren1,
    input  logic               E_mem_wen1,
    input  mem_op_e            E_mem_op1,
    input  logic [`MEM_DW-1:0] E_mem_addr1,
    input  logic [`MEM_DW-1:0] E_mem_wdata1,
    input  logic               E_exp1,
    output logic               E_mem_adel1,
    output logic               E_mem_ades1,
    // slot B
    input  logic               E_mem_en2,
    input  logic               E_mem_ren2,
    input  logic               E_mem_wen2,
    input  mem_op_e            E_mem_op2,
    input  logic [`MEM_DW-1:0] E_mem_addr2,
    input  logic [`MEM_DW-1:0] E_mem_wdata2,
    input  logic               E_exp2,
    output logic               E_mem_ades2,
    output logic               E_mem_adel2,
    // pipeline control
    input  logic               M_flush,
    input  logic               M_ena,
    // load data
    output logic [`MEM_DW-1:0] M_mem_rdata1,
    output logic [`MEM_DW-1:0] M_mem_rdata2
);

    logic               E_mem_sel1;
    logic               E_mem_sel2;
    logic               E_mem_en;
    logic               E_mem_ren;
    logic               E_mem_wen;
    mem_op_e            E_mem_op;
    logic [`MEM_DW-1:0] E_mem_addr;
    logic [`MEM_DW-1:0] E_mem_wdata;
    logic [3:0]         ram_we;
    logic [`MEM_AW-1:0] ram_addr;
    logic [`MEM_DW-1:0] ram_wdata;
    logic [`MEM_DW-1:0] ram_rdata;
    logic               M_mem_sel1;
    logic               M_mem_sel2;
    mem_op_e            M_mem_op;
    logic [1:0]         M_addr_lo;

    struct_conflict conflict_i (.*);

    mem_align align_i (
        .E_mem_en     (E_mem_en),
        .E_mem_wen    (E_mem_wen),
        .E_mem_op     (E_mem_op),
        .E_mem_addr   (E_mem_addr),
        .E_mem_wdata  (E_mem_wdata),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .M_mem_sel1   (M_mem_sel1),
        .M_mem_sel2   (M_mem_sel2),
        .M_mem_op     (M_mem_op),
        .M_addr_lo    (M_addr_lo),
        .ram_rdata    (ram_rdata),
        .M_mem_rdata1 (M_mem_rdata1),
        .M_mem_rdata2 (M_mem_rdata2)
    );

    em_pipe_reg em_reg_i (
        .clk        (clk),
        .rst        (rst),
        .M_ena      (M_ena),
        .M_flush    (M_flush),
        .E_mem_sel1 (E_mem_sel1),
        .E_mem_sel2 (E_mem_sel2),
        .E_mem_op   (E_mem_op),
        .E_addr_lo  (E_mem_addr[1:0]),
        .M_mem_sel1 (M_mem_sel1),
        .M_mem_sel2 (M_mem_sel2),
        .M_mem_op   (M_mem_op),
        .M_addr_lo  (M_addr_lo)
    );

    data_ram #(
        .DEPTH_LOG2 (`MEM_AW)
    ) ram_i (
        .clk   (clk),
        .rst   (rst),
        .en    (E_mem_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // a merged access is a read or a write, never both
    a_rw_excl: assert property (
        @(posedge clk) disable iff (rst) !(E_mem_ren && E_mem_wen)
    ) else $error("merged request is both read and write");

endmodule

//--- tb_mem_stage.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module tb_mem_stage import mem_pkg::*; ();

    localparam int N_RAND     = 24;
    localparam int REQ_TOTAL  = N_RAND * 6 + 29;
    localparam int MAX_CYCLES = 4 * REQ_TOTAL + 200;

    logic               clk = 1'b0;
    logic               rst;
    logic               E_mem_en1, E_mem_ren1, E_mem_wen1, E_exp1;
    logic               E_mem_en2, E_mem_ren2, E_mem_wen2, E_exp2;
    mem_op_e            E_mem_op1, E_mem_op2;
    logic [`MEM_DW-1:0] E_mem_addr1, E_mem_wdata1, E_mem_addr2, E_mem_wdata2;
    logic               E_mem_adel1, E_mem_ades1, E_mem_adel2, E_mem_ades2;
    logic               M_flush, M_ena;
    logic [`MEM_DW-1:0] M_mem_rdata1, M_mem_rdata2;

    logic [31:0] ref_mem [0:(1 << `MEM_AW)-1];
    logic [31:0] pend_r1, pend_r2, exp_r1, exp_r2;
    logic        chk_on;
    int          cycle_cnt = 0;

    mem_stage_top dut_i (.*);

    always #10 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "mismatch, stopping");
    endtask

    task automatic check_rdata(input int slot, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("slot %0d rdata %h expected %h", slot, got, exp));
        end
    endtask

    task automatic check_exc(input int slot, input logic adel, input logic ades,
                             input logic [1:0] exp);
        if ({adel, ades} !== exp) begin
            report_fail($sformatf("slot %0d adel/ades %b%b expected %b", slot, adel, ades, exp));
        end
    endtask

    function automatic logic is_load(input mem_op_e op);
        return (op == OP_LB) || (op == OP_LH) || (op == OP_LW) ||
               (op == OP_LBU) || (op == OP_LHU);
    endfunction

    // {adel, ades} from the alignment rules
    function automatic logic [1:0] exp_exc(input mem_op_e op, input logic [1:0] lo);
        case (op)
            OP_LW:         return {|lo, 1'b0};
            OP_LH, OP_LHU: return {lo[0], 1'b0};
            OP_SW:         return {1'b0, |lo};
            OP_SH:         return {1'b0, lo[0]};
            default:       return 2'b00;
        endcase
    endfunction

    // expected load value from the model word
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [1:0] lo,
                                             input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*lo +: 8];
        h = lo[1] ? word[31:16] : word[15:0];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic model_store(input mem_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata);
        logic [9:0] w;
        w = addr[11:2];
        case (op)
            OP_SB:   ref_mem[w][8*addr[1:0] +: 8] = wdata[7:0];
            OP_SH:   ref_mem[w][16*addr[1] +: 16] = wdata[15:0];
            default: ref_mem[w] = wdata;
        endcase
    endtask

    // one request per cycle, slot 0 means idle
    task automatic issue(input int slot, input mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic x1, input logic x2,
                         input logic flush, input logic ena);
        logic [1:0]  e1;
        logic [1:0]  e2;
        logic        s1;
        logic        s2;
        logic        go;
        logic [31:0] val;
        @(posedge clk);
        exp_r1 = pend_r1;
        exp_r2 = pend_r2;
        E_mem_en1    <= (slot == 1);
        E_mem_ren1   <= (slot == 1) && is_load(op);
        E_mem_wen1   <= (slot == 1) && !is_load(op);
        E_mem_op1    <= (slot == 1) ? op : OP_NONE;
        E_mem_en2    <= (slot == 2);
        E_mem_ren2   <= (slot == 2) && is_load(op);
        E_mem_wen2   <= (slot == 2) && !is_load(op);
        E_mem_op2    <= (slot == 2) ? op : OP_NONE;
        E_mem_addr1  <= addr;
        E_mem_addr2  <= addr;
        E_mem_wdata1 <= wdata;
        E_mem_wdata2 <= wdata;
        E_exp1       <= x1;
        E_exp2       <= x2;
        M_flush      <= flush;
        M_ena        <= ena;
        e1 = (slot == 1) ? exp_exc(op, addr[1:0]) : 2'b00;
        e2 = (slot == 2) ? exp_exc(op, addr[1:0]) : 2'b00;
        s1 = (slot == 1) && !x1 && (e1 == 2'b00);
        s2 = (slot == 2) && !x1 && !x2 && (e2 == 2'b00);
        go = (s1 || s2) && ena && !flush;
        // stall keeps the previous M result
        if (ena) begin
            pend_r1 = '0;
            pend_r2 = '0;
            if (go && is_load(op)) begin
                val = ref_load(op, addr[1:0], ref_mem[addr[11:2]]);
                if (s1) begin
                    pend_r1 = val;
                end else begin
                    pend_r2 = val;
                end
            end
            if (go && !is_load(op)) begin
                model_store(op, addr, wdata);
            end
        end
        @(negedge clk);
        check_exc(1, E_mem_adel1, E_mem_ades1, e1);
        check_exc(2, E_mem_adel2, E_mem_ades2, e2);
    endtask

    task automatic idle(input logic ena);
        issue(0, OP_NONE, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0, ena);
    endtask

    function automatic logic [31:0] rand_word_addr();
        logic [31:0] r;
        r = $urandom;
        return {20'd0, r[9:0], 2'b00};
    endfunction

    always @(negedge clk) begin
        if (chk_on) begin
            check_rdata(1, M_mem_rdata1, exp_r1);
            check_rdata(2, M_mem_rdata2, exp_r2);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, test did not finish");
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        int          slot;
        int          n;
        logic [31:0] a;
        logic [31:0] r;
        logic [1:0]  lo;
        mem_op_e     sop;
        void'($urandom(32'h0fa1_9011));
        rst <= 1'b1;
        chk_on = 1'b0;
        {E_mem_en1, E_mem_ren1, E_mem_wen1, E_exp1} <= '0;
        {E_mem_en2, E_mem_ren2, E_mem_wen2, E_exp2} <= '0;
        E_mem_op1 <= OP_NONE;
        E_mem_op2 <= OP_NONE;
        {E_mem_addr1, E_mem_wdata1, E_mem_addr2, E_mem_wdata2} <= '0;
        M_flush <= 1'b0;
        M_ena <= 1'b1;
        {pend_r1, pend_r2, exp_r1, exp_r2} = '0;
        for (int i = 0; i < (1 << `MEM_AW); i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        chk_on = 1'b1;

        // random aligned stores, each read back with every load size
        for (int i = 0; i < N_RAND; i++) begin
            slot = 1 + int'($urandom % 2);
            a = rand_word_addr();
            r = $urandom;
            case (r % 3)
                0: begin
                    sop = OP_SB;
                    lo = r[5:4];
                end
                1: begin
                    sop = OP_SH;
                    lo = {r[5], 1'b0};
                end
                default: begin
                    sop = OP_SW;
                    lo = 2'b00;
                end
            endcase
            issue(slot, sop, a | 32'(lo), $urandom, 1'b0, 1'b0, 1'b0, 1'b1);
            r = $urandom;
            issue(slot, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
            issue(slot, OP_LB, a | 32'(r[1:0]), 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
            issue(slot, OP_LBU, a | 32'(r[3:2]), 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
            issue(slot, OP_LH, a | {30'd0, r[4], 1'b0}, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
            issue(slot, OP_LHU, a | {30'd0, r[5], 1'b0}, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        idle(1'b1);

        // misaligned accesses raise flags and do nothing else
        a = rand_word_addr();
        issue(1, OP_SW, a, 32'h8765_4321, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(1, OP_LW, a | 32'd1, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(2, OP_LH, a | 32'd3, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(1, OP_LHU, a | 32'd1, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(2, OP_SW, a | 32'd2, 32'hdead_beef, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(1, OP_SH, a | 32'd1, 32'hdead_beef, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(1, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);

        // slot A exception kills B, slot B exception leaves A alone
        issue(2, OP_SW, a, 32'h1111_2222, 1'b1, 1'b0, 1'b0, 1'b1);
        issue(2, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(1, OP_SW, a, 32'h3333_4444, 1'b0, 1'b1, 1'b0, 1'b1);
        issue(1, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);

        // flushed store and load
        issue(1, OP_SW, a, 32'h5555_6666, 1'b0, 1'b0, 1'b1, 1'b1);
        issue(2, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b1, 1'b1);
        issue(2, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);

        // stall holds load data and blocks a store
        issue(1, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        n = 2 + int'($urandom % 6);
        for (int i = 0; i < n; i++) begin
            idle(1'b0);
        end
        issue(2, OP_SW, a, 32'h7777_8888, 1'b0, 1'b0, 1'b0, 1'b0);
        idle(1'b0);
        idle(1'b1);
        issue(2, OP_LW, a, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        idle(1'b1);
        idle(1'b1);

        $display("sim passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
mem_pkg.sv
struct_conflict.sv
mem_align.sv
em_pipe_reg.sv
data_ram.sv
mem_stage_top.sv
tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_mem_stage \
    -o sim_mem_stage

./obj_dir/sim_mem_stage
